//--- if_pkg.sv
/*
 * Instruction fetch package
 * PC-mux codes, widths, buffer depth and the buffered fetch entry
 */

package if_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int unsigned XLEN         = 32; // Data and address width
  localparam int unsigned MTVEC_ADDR_W = 25; // Trap base field
  localparam int unsigned IRQ_ID_W     = 5;  // Interrupt id for vectoring

  // Default instruction buffer depth
  localparam int unsigned ALBUF_DEPTH  = 3;

  ////////////////////////////////////////
  // Redirect source select
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0, // Boot address
    PC_JUMP     = 3'd1, // Jump target from ID
    PC_BRANCH   = 3'd2, // Branch target from EX
    PC_MRET     = 3'd3, // Return from trap
    PC_DRET     = 3'd4, // Return from debug
    PC_TRAP_IRQ = 3'd5, // Vectored interrupt
    PC_TRAP_DBD = 3'd6  // Debug halt entry
  } pc_mux_e;

  // One completed fetch as held in the buffer
  typedef struct packed {
    logic [XLEN-1:0] pc;    // Fetch address
    logic [XLEN-1:0] instr; // Instruction word
    logic            err;   // Bus error on this fetch
  } fetch_entry_t;

endpackage

//--- fetch_out_if.sv
/*
 * Buffered instruction channel
 * Carries the buffer head from the prefetch unit to the IF/ID register
 */

interface fetch_out_if;

  logic                 valid; // Buffer not empty
  logic                 ready; // IF/ID takes the head
  if_pkg::fetch_entry_t entry; // Buffer head

  // Prefetch side
  modport src (
    output valid,
    output entry,
    input  ready
  );

  // IF/ID register side
  modport dst (
    input  valid,
    input  entry,
    output ready
  );

endinterface

//--- pc_select.sv
/*
 * Next fetch address selection
 * Picks the redirect target and flags mtvec init on boot
 */

module pc_select (
  input  logic                                pc_set_i,        // Redirect this cycle
  input  if_pkg::pc_mux_e                     pc_mux_i,        // Redirect source
  input  logic [if_pkg::XLEN-1:0]             boot_addr_i,
  input  logic [if_pkg::XLEN-1:0]             jump_target_i,
  input  logic [if_pkg::XLEN-1:0]             branch_target_i,
  input  logic [if_pkg::XLEN-1:0]             mepc_i,
  input  logic [if_pkg::XLEN-1:0]             dpc_i,
  input  logic [if_pkg::XLEN-1:0]             dm_halt_addr_i,
  input  logic [if_pkg::MTVEC_ADDR_W-1:0]     mtvec_addr_i,    // Trap base MSBs
  input  logic [if_pkg::IRQ_ID_W-1:0]         irq_id_i,        // Vector index
  output logic [if_pkg::XLEN-1:0]             target_o,        // Redirect address
  output logic                                csr_mtvec_init_o // Init mtvec in CSR file
);

  // Target mux
  always_comb begin
    case (pc_mux_i)
      if_pkg::PC_BOOT:     target_o = {boot_addr_i[31:2], 2'b00}; // Word aligned
      if_pkg::PC_JUMP:     target_o = jump_target_i;
      if_pkg::PC_BRANCH:   target_o = branch_target_i;
      if_pkg::PC_MRET:     target_o = mepc_i;                     // Back to trapped PC
      if_pkg::PC_DRET:     target_o = dpc_i;
      // Base, then interrupt id, then word offset
      if_pkg::PC_TRAP_IRQ: target_o = {mtvec_addr_i, irq_id_i, 2'b00};
      if_pkg::PC_TRAP_DBD: target_o = {dm_halt_addr_i[31:2], 2'b00};
      default:             target_o = {boot_addr_i[31:2], 2'b00}; // Unused code
    endcase
  end

  // Boot redirect also initialises the trap base
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == if_pkg::PC_BOOT);

endmodule

//--- fetch_fifo.sv
/*
 * Small synchronous FIFO
 * Circular buffer with a payload type parameter and a one-edge flush
 */

module fetch_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter type         T     = logic [31:0],
  localparam int unsigned CNT_W = $clog2(DEPTH + 1),
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i, // Drop all entries
  input  logic             push_i,
  input  T                 wdata_i,
  input  logic             pop_i,
  output T                 rdata_o, // Oldest entry
  output logic             empty_o,
  output logic [CNT_W-1:0] count_o
);

  T                 mem [DEPTH]; // Storage
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Wrap for non power-of-two depths
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_pop  = pop_i && !empty_o;  // Pop on empty ignored
  assign do_push = push_i && !flush_i; // Flush wins over push

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= wdata_i;
    end
  end

  assign rdata_o = mem[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

endmodule

//--- prefetch_unit.sv
/*
 * Prefetch unit
 * Issues word fetches, tracks outstanding requests, drops stale
 * responses after a redirect and buffers completed fetches
 */

module prefetch_unit #(
  parameter int unsigned MAX_OUTSTANDING = 2,
  parameter int unsigned BUF_DEPTH       = if_pkg::ALBUF_DEPTH
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    pc_set_i,  // Redirect
  input  logic [if_pkg::XLEN-1:0] target_i,  // Redirect address
  input  logic                    kill_i,    // Discard buffer head
  // Instruction bus
  output logic                    req_o,
  output logic [if_pkg::XLEN-1:0] addr_o,
  input  logic                    gnt_i,
  input  logic                    rvalid_i,
  input  logic [if_pkg::XLEN-1:0] rdata_i,
  input  logic                    err_i,
  output logic                    busy_o,    // Requests in flight
  fetch_out_if.src                fetch_out
);

  localparam int unsigned OUT_W     = $clog2(MAX_OUTSTANDING + 1);
  localparam int unsigned BUF_CNT_W = $clog2(BUF_DEPTH + 1);

  logic                    active_q;      // Set by first redirect
  logic [if_pkg::XLEN-1:0] fetch_addr_q;
  logic [OUT_W-1:0]        outstanding_q; // Granted, not yet answered
  logic [OUT_W-1:0]        outstanding_n;
  logic [OUT_W-1:0]        discard_q;     // Stale responses still to drop
  logic                    grant;
  logic                    resp_take;     // Response goes to the buffer
  logic                    issue_ok;
  logic [31:0]             inflight;      // Outstanding plus buffered

  logic [if_pkg::XLEN-1:0] resp_addr;     // Address paired with response
  logic                    addr_empty;
  if_pkg::fetch_entry_t    resp_entry;
  logic                    buf_empty;
  logic [BUF_CNT_W-1:0]    buf_count;
  logic                    buf_pop;

  ////////////////////////////////////////
  // Request issue
  ////////////////////////////////////////

  assign inflight = 32'(outstanding_q) + 32'(buf_count);
  assign issue_ok = (inflight < 32'(BUF_DEPTH)) &&
                    (outstanding_q < OUT_W'(MAX_OUTSTANDING));

  assign req_o  = active_q && issue_ok;
  assign addr_o = fetch_addr_q;
  assign grant  = req_o && gnt_i;
  assign busy_o = (outstanding_q != '0);

  assign outstanding_n = outstanding_q + OUT_W'(grant) - OUT_W'(rvalid_i);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      fetch_addr_q <= '0;
    end else if (pc_set_i) begin
      active_q     <= 1'b1;
      fetch_addr_q <= {target_i[31:2], 2'b00}; // Fetch whole words only
    end else if (grant) begin
      fetch_addr_q <= fetch_addr_q + 32'd4;    // Next word
    end
  end

  ////////////////////////////////////////
  // Outstanding and discard tracking
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      discard_q     <= '0;
    end else begin
      outstanding_q <= outstanding_n;
      if (pc_set_i) begin
        discard_q <= outstanding_n;          // Everything in flight is stale now
      end else if (rvalid_i && (discard_q != '0)) begin
        discard_q <= discard_q - 1'b1;       // Drop one stale response
      end
    end
  end

  // Live response, paired with the oldest granted address
  assign resp_take = rvalid_i && (discard_q == '0) && !addr_empty && !pc_set_i;

  fetch_fifo #(
    .DEPTH (MAX_OUTSTANDING),
    .T     (logic [if_pkg::XLEN-1:0])
  ) addr_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (pc_set_i),
    .push_i  (grant),
    .wdata_i (fetch_addr_q),
    .pop_i   (resp_take),
    .rdata_o (resp_addr),
    .empty_o (addr_empty),
    .count_o ()
  );

  ////////////////////////////////////////
  // Instruction buffer
  ////////////////////////////////////////

  always_comb begin
    resp_entry.pc    = resp_addr;
    resp_entry.instr = rdata_i;
    resp_entry.err   = err_i;
  end

  // Kill drops the head whatever ready says
  assign buf_pop = (fetch_out.valid && fetch_out.ready) || kill_i;

  fetch_fifo #(
    .DEPTH (BUF_DEPTH),
    .T     (if_pkg::fetch_entry_t)
  ) buf_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (pc_set_i),
    .push_i  (resp_take),
    .wdata_i (resp_entry),
    .pop_i   (buf_pop),
    .rdata_o (fetch_out.entry),
    .empty_o (buf_empty),
    .count_o (buf_count)
  );

  assign fetch_out.valid = !buf_empty;

endmodule

//--- if_id_register.sv
/*
 * IF/ID pipeline register
 * Takes the buffer head under halt, kill and ID back-pressure
 */

module if_id_register (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    halt_i,      // No transfer out of the buffer
  input  logic                    kill_i,      // Head discarded, nothing loaded
  input  logic                    id_ready_i,  // ID can take an instruction
  output logic                    instr_valid_o,
  output logic [if_pkg::XLEN-1:0] instr_o,
  output logic [if_pkg::XLEN-1:0] pc_o,
  output logic                    bus_err_o,
  output logic                    illegal_c_o, // Not a 32-bit encoding
  fetch_out_if.dst                fetch_out
);

  logic load;     // Head moves into the register
  logic illegal;  // Low bits not 2'b11

  // Halt blocks the transfer, kill is taken care of upstream
  assign fetch_out.ready = id_ready_i && !halt_i;

  assign load = fetch_out.valid && fetch_out.ready && !kill_i;

  // Compressed words are not expanded here, only flagged
  assign illegal = (fetch_out.entry.instr[1:0] != 2'b11) && !fetch_out.entry.err;

  ////////////////////////////////////////
  // Valid
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_o <= 1'b0;
    end else if (load) begin
      instr_valid_o <= 1'b1;
    end else if (id_ready_i) begin
      instr_valid_o <= 1'b0; // Consumed, nothing new
    end
    // id_ready_i low holds everything
  end

  // Payload, only written on a load
  always_ff @(posedge clk) begin
    if (load) begin
      instr_o     <= fetch_out.entry.instr;
      pc_o        <= fetch_out.entry.pc;
      bus_err_o   <= fetch_out.entry.err;
      illegal_c_o <= illegal;
    end
  end

endmodule

//--- if_stage.sv
/*
 * Instruction fetch stage
 * Next-PC select, prefetch with buffering and the IF/ID register
 */

module if_stage #(
  parameter int unsigned MAX_OUTSTANDING = 2,                  // Bus requests in flight
  parameter int unsigned BUF_DEPTH       = if_pkg::ALBUF_DEPTH // Buffered fetches
) (
  input  logic                            clk,
  input  logic                            rst_n,
  // Redirect control
  input  logic                            pc_set_i,
  input  if_pkg::pc_mux_e                 pc_mux_i,
  input  logic [if_pkg::XLEN-1:0]         boot_addr_i,
  input  logic [if_pkg::XLEN-1:0]         jump_target_i,
  input  logic [if_pkg::XLEN-1:0]         branch_target_i,
  input  logic [if_pkg::XLEN-1:0]         mepc_i,
  input  logic [if_pkg::XLEN-1:0]         dpc_i,
  input  logic [if_pkg::XLEN-1:0]         dm_halt_addr_i,
  input  logic [if_pkg::MTVEC_ADDR_W-1:0] mtvec_addr_i,
  input  logic [if_pkg::IRQ_ID_W-1:0]     irq_id_i,
  // Stage control
  input  logic                            halt_if_i,
  input  logic                            kill_if_i,
  input  logic                            id_ready_i,
  // Instruction bus
  output logic                            instr_req_o,
  output logic [if_pkg::XLEN-1:0]         instr_addr_o,
  input  logic                            instr_gnt_i,
  input  logic                            instr_rvalid_i,
  input  logic [if_pkg::XLEN-1:0]         instr_rdata_i,
  input  logic                            instr_err_i,
  // To ID
  output logic                            instr_valid_o,
  output logic [if_pkg::XLEN-1:0]         instr_o,
  output logic [if_pkg::XLEN-1:0]         pc_id_o,
  output logic                            bus_err_o,
  output logic                            illegal_c_o,
  // Status
  output logic                            if_busy_o,
  output logic                            csr_mtvec_init_o
);

  logic [if_pkg::XLEN-1:0] target; // Redirect address

  fetch_out_if fetch_out ();        // Buffer head to IF/ID

  pc_select pc_select_i (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .dpc_i            (dpc_i),
    .dm_halt_addr_i   (dm_halt_addr_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .target_o         (target),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  prefetch_unit #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING),
    .BUF_DEPTH       (BUF_DEPTH)
  ) prefetch_unit_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_set_i  (pc_set_i),
    .target_i  (target),
    .kill_i    (kill_if_i),
    .req_o     (instr_req_o),
    .addr_o    (instr_addr_o),
    .gnt_i     (instr_gnt_i),
    .rvalid_i  (instr_rvalid_i),
    .rdata_i   (instr_rdata_i),
    .err_i     (instr_err_i),
    .busy_o    (if_busy_o),
    .fetch_out (fetch_out.src)
  );

  if_id_register if_id_register_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .halt_i        (halt_if_i),
    .kill_i        (kill_if_i),
    .id_ready_i    (id_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .pc_o          (pc_id_o),
    .bus_err_o     (bus_err_o),
    .illegal_c_o   (illegal_c_o),
    .fetch_out     (fetch_out.dst)
  );

endmodule

//--- if_stage_checker.sv
/*
 * Bus and pipeline assertions for the fetch stage
 * Bound into if_stage
 */

module if_stage_checker #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input logic                                     clk,
  input logic                                     rst_n,
  input logic                                     pc_set_i,
  input logic                                     req_i,
  input logic                                     gnt_i,
  input logic [31:0]                              addr_i,
  input logic [$clog2(MAX_OUTSTANDING + 1)-1:0]   outstanding_i,
  input logic                                     id_ready_i,
  input logic                                     valid_i,
  input logic [31:0]                              instr_i,
  input logic [31:0]                              pc_i
);

  int failures = 0; // Assertion failures so far

  // Request held with a stable address until granted, redirect excepted
  req_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    req_i && !gnt_i && !pc_set_i |=> req_i && $stable(addr_i))
    else begin
      $error("request dropped or address changed before grant");
      failures++;
    end

  outstanding_max_a : assert property (@(posedge clk) disable iff (!rst_n)
    32'(outstanding_i) <= MAX_OUTSTANDING)
    else begin
      $error("outstanding count above limit");
      failures++;
    end

  // ID back-pressure freezes the IF/ID outputs
  hold_stable_a : assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i && valid_i |=> $stable(valid_i) && $stable(instr_i) && $stable(pc_i))
    else begin
      $error("IF/ID outputs moved while ID was stalled");
      failures++;
    end

endmodule

bind if_stage if_stage_checker #(
  .MAX_OUTSTANDING (MAX_OUTSTANDING)
) assert_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .pc_set_i      (pc_set_i),
  .req_i         (instr_req_o),
  .gnt_i         (instr_gnt_i),
  .addr_i        (instr_addr_o),
  .outstanding_i (prefetch_unit_i.outstanding_q),
  .id_ready_i    (id_ready_i),
  .valid_i       (instr_valid_o),
  .instr_i       (instr_o),
  .pc_i          (pc_id_o)
);

//--- if_stage_monitor.sv
/*
 * Fetch stream monitor
 * Predicts PC, word and flags after each redirect and compares accepts
 */

module if_stage_monitor (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  pc_set_i,
  input if_pkg::pc_mux_e       pc_mux_i,
  input logic [31:0]           boot_addr_i,
  input logic [31:0]           jump_target_i,
  input logic [31:0]           branch_target_i,
  input logic [31:0]           mepc_i,
  input logic [31:0]           dpc_i,
  input logic [31:0]           dm_halt_addr_i,
  input logic [24:0]           mtvec_addr_i,
  input logic [4:0]            irq_id_i,
  input logic                  halt_if_i,
  input logic                  id_ready_i,
  input logic                  valid_i,
  input logic [31:0]           instr_i,
  input logic [31:0]           pc_i,
  input logic                  bus_err_i,
  input logic                  illegal_i,
  input logic                  mtvec_init_i,
  input logic                  req_i,        // Bus request
  input logic                  gnt_i,        // Bus grant
  input logic                  rvalid_i,     // Bus response
  input logic                  busy_i,       // Fetch busy status
  input logic [31:0]           err_lo_i,     // Error window, inclusive
  input logic [31:0]           err_hi_i      // Error window, exclusive
);

  string       name = "none";
  int          accepted;
  int          errors;
  int          test_errors;
  int          tests;
  int          checks;
  int          outstanding; // Granted on the bus, not yet answered
  logic        armed;      // Set by the redirect of the current test
  logic        halt_q;
  logic        ready_q;
  logic [31:0] exp_pc;

  // Memory rule: inverted word address, low bits 10 when bits 5:2 all ones
  function automatic logic [31:0] rule_word(input logic [31:0] a);
    rule_word = {~a[31:2], (a[5:2] == 4'hf) ? 2'b10 : 2'b11};
  endfunction

  function automatic logic [31:0] redirect_target();
    case (pc_mux_i)
      if_pkg::PC_JUMP:     redirect_target = jump_target_i;
      if_pkg::PC_BRANCH:   redirect_target = branch_target_i;
      if_pkg::PC_MRET:     redirect_target = mepc_i;
      if_pkg::PC_DRET:     redirect_target = dpc_i;
      if_pkg::PC_TRAP_IRQ: redirect_target = {mtvec_addr_i, irq_id_i, 2'b00};
      if_pkg::PC_TRAP_DBD: redirect_target = dm_halt_addr_i & 32'hffff_fffc;
      default:             redirect_target = boot_addr_i & 32'hffff_fffc;
    endcase
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("mismatch %s %s: expected %h actual %h", name, what, exp, act);
    end
  endtask

  task automatic begin_test(input string n);
    name        = n;
    accepted    = 0;
    test_errors = 0;
    armed       = 1'b0; // Old stream no longer counted
  endtask

  task automatic end_test();
    tests++;
    $display("%-12s %s  %0d accepted, %0d errors", name,
             (test_errors == 0) ? "ok  " : "FAIL", accepted, test_errors);
  endtask

  task automatic summary();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
  endtask

  ////////////////////////////////////////
  // Sampled mid-cycle, transfer happens at the next rising edge
  ////////////////////////////////////////

  always @(negedge clk) begin
    logic [31:0] exp_word;
    logic [31:0] tgt;
    logic        exp_err;
    if (rst_n) begin
      // Busy while anything granted is still unanswered
      compare("busy", 32'(outstanding != 0), 32'(busy_i));
      outstanding = outstanding + int'(req_i && gnt_i) - int'(rvalid_i);
      if (halt_q && ready_q && valid_i) begin
        errors++;
        test_errors++;
        $display("%s: an instruction came out while fetch was halted", name);
      end
      if (armed && valid_i && id_ready_i) begin
        exp_word = rule_word(exp_pc);
        exp_err  = (exp_pc >= err_lo_i) && (exp_pc < err_hi_i);
        compare("pc", exp_pc, pc_i);
        compare("instr", exp_word, instr_i);
        compare("bus_err", 32'(exp_err), 32'(bus_err_i));
        compare("illegal_c", 32'((exp_word[1:0] != 2'b11) && !exp_err), 32'(illegal_i));
        exp_pc = exp_pc + 32'd4;
        accepted++;
      end
      if (pc_set_i) begin
        compare("mtvec_init", 32'(pc_mux_i == if_pkg::PC_BOOT), 32'(mtvec_init_i));
        tgt    = redirect_target();
        exp_pc = {tgt[31:2], 2'b00}; // Fetch starts at the word
        armed  = 1'b1;
      end
      halt_q  = halt_if_i;
      ready_q = id_ready_i;
    end
  end

endmodule

//--- tb_if_stage.sv
/*
 * Testbench for the fetch stage
 * Clock, reset, bus memory model, stimulus table and timeout
 */

module tb_if_stage;

  localparam int NT = 10; // Table rows

  logic            clk = 1'b0;
  logic            rst_n;
  logic            pc_set_i, halt_if_i, kill_if_i, id_ready_i;
  if_pkg::pc_mux_e pc_mux_i;
  logic [31:0]     boot_addr_i, jump_target_i, branch_target_i;
  logic [31:0]     mepc_i, dpc_i, dm_halt_addr_i;
  logic [24:0]     mtvec_addr_i;
  logic [4:0]      irq_id_i;
  logic            instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic [31:0]     instr_rdata_i;
  logic            instr_req_o, instr_valid_o, bus_err_o, illegal_c_o;
  logic            if_busy_o, csr_mtvec_init_o;
  logic [31:0]     instr_addr_o, instr_o, pc_id_o;

  // Stimulus table
  string           t_name [NT];
  if_pkg::pc_mux_e t_mux [NT];
  logic [31:0]     t_addr [NT];
  logic [24:0]     t_mtvec [NT];
  logic [4:0]      t_irq [NT];
  logic [1:0]      t_hk [NT];   // bit 0 halt window, bit 1 kill with redirect
  logic            t_rdy [NT];  // Random ready gaps
  logic [31:0]     t_elo [NT];
  logic [31:0]     t_ehi [NT];
  int              t_n [NT];    // Instructions to accept
  int              rows;

  logic [31:0]     err_lo, err_hi;
  logic [31:0]     pend_addr [$]; // Granted, not answered
  int              pend_due [$];
  int              cyc, gnt_wait, cycles, timeout_limit;

  always #10 clk = ~clk;

  if_stage dut_i (.*);

  if_stage_monitor mon (
    .clk (clk), .rst_n (rst_n), .pc_set_i (pc_set_i), .pc_mux_i (pc_mux_i),
    .boot_addr_i (boot_addr_i), .jump_target_i (jump_target_i),
    .branch_target_i (branch_target_i), .mepc_i (mepc_i), .dpc_i (dpc_i),
    .dm_halt_addr_i (dm_halt_addr_i), .mtvec_addr_i (mtvec_addr_i), .irq_id_i (irq_id_i),
    .halt_if_i (halt_if_i), .id_ready_i (id_ready_i), .valid_i (instr_valid_o),
    .instr_i (instr_o), .pc_i (pc_id_o), .bus_err_i (bus_err_o), .illegal_i (illegal_c_o),
    .mtvec_init_i (csr_mtvec_init_o),
    .req_i (instr_req_o), .gnt_i (instr_gnt_i), .rvalid_i (instr_rvalid_i),
    .busy_i (if_busy_o), .err_lo_i (err_lo), .err_hi_i (err_hi)
  );

  ////////////////////////////////////////
  // Memory model, in-order responses
  ////////////////////////////////////////

  always @(posedge clk) begin
    cyc++;
    #2;
    instr_rvalid_i = 1'b0;
    if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = {~pend_addr[0][31:2], (pend_addr[0][5:2] == 4'hf) ? 2'b10 : 2'b11};
      instr_err_i    = (pend_addr[0] >= err_lo) && (pend_addr[0] < err_hi);
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
    instr_gnt_i = 1'b0;
    if (rst_n && instr_req_o) begin
      if (gnt_wait == 0) begin
        instr_gnt_i = 1'b1;            // Handshake at the next edge
        pend_addr.push_back(instr_addr_o);
        pend_due.push_back(cyc + 1 + int'($urandom % 3));
        gnt_wait = int'($urandom % 3);
      end else begin
        gnt_wait--;
      end
    end
  end

  // Timeout
  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_limit) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic add_row(input string n, input if_pkg::pc_mux_e m, input logic [31:0] a,
                         input logic [24:0] mt, input logic [4:0] irq, input logic [1:0] hk,
                         input logic rdy, input logic [31:0] elo, input logic [31:0] ehi,
                         input int cnt);
    t_name[rows] = n;
    t_mux[rows]  = m;
    t_addr[rows] = a;
    t_mtvec[rows] = mt;
    t_irq[rows]  = irq;
    t_hk[rows]   = hk;
    t_rdy[rows]  = rdy;
    t_elo[rows]  = elo;
    t_ehi[rows]  = ehi;
    t_n[rows]    = cnt;
    rows++;
  endtask

  task automatic run_test(input int r);
    int k;
    @(posedge clk);
    #2;
    err_lo          = t_elo[r];
    err_hi          = t_ehi[r];
    // Unselected sources get distinct junk so a wrong mux shows up
    boot_addr_i     = 32'h0bad_0003;
    jump_target_i   = 32'h0bad_1004;
    branch_target_i = 32'h0bad_2008;
    mepc_i          = 32'h0bad_300c;
    dpc_i           = 32'h0bad_4010;
    dm_halt_addr_i  = 32'h0bad_5017;
    mtvec_addr_i    = t_mtvec[r];
    irq_id_i        = t_irq[r];
    case (t_mux[r])
      if_pkg::PC_BOOT:     boot_addr_i = t_addr[r];
      if_pkg::PC_JUMP:     jump_target_i = t_addr[r];
      if_pkg::PC_BRANCH:   branch_target_i = t_addr[r];
      if_pkg::PC_MRET:     mepc_i = t_addr[r];
      if_pkg::PC_DRET:     dpc_i = t_addr[r];
      if_pkg::PC_TRAP_DBD: dm_halt_addr_i = t_addr[r];
      default:             ;
    endcase
    mon.begin_test(t_name[r]);
    pc_set_i   = 1'b1;
    pc_mux_i   = t_mux[r];
    kill_if_i  = t_hk[r][1];
    id_ready_i = 1'b1; // ID takes the kill, old IF/ID content drops
    halt_if_i  = 1'b0;
    @(posedge clk);
    #2;
    pc_set_i  = 1'b0;
    kill_if_i = 1'b0;
    k = 0;
    while (mon.accepted < t_n[r]) begin
      halt_if_i  = t_hk[r][0] && (k >= 4) && (k < 12);
      id_ready_i = t_rdy[r] ? (($urandom % 10) < 7) : 1'b1;
      @(posedge clk);
      #2;
      k++;
    end
    id_ready_i = 1'b1;
    halt_if_i  = 1'b0;
    mon.end_test();
  endtask

  initial begin
    int total;
    void'($urandom(32'h2a72));
    rst_n           = 1'b0;
    pc_set_i        = 1'b0;
    pc_mux_i        = if_pkg::PC_BOOT;
    halt_if_i       = 1'b0;
    kill_if_i       = 1'b0;
    id_ready_i      = 1'b1;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    dpc_i           = '0;
    dm_halt_addr_i  = '0;
    mtvec_addr_i    = '0;
    irq_id_i        = '0;
    instr_gnt_i     = 1'b0;
    instr_rvalid_i  = 1'b0;
    instr_rdata_i   = '0;
    instr_err_i     = 1'b0;
    err_lo          = '0;
    err_hi          = '0;
    timeout_limit   = 1 << 30;
    //      name          mux                   addr          mtvec      irq  hk   rdy  elo ehi n
    add_row("boot",       if_pkg::PC_BOOT,     32'h0000_1003, 25'h0,    5'd0, 2'b00, 1'b0, 0, 0, 10);
    add_row("jump",       if_pkg::PC_JUMP,     32'h0000_2040, 25'h0,    5'd0, 2'b10, 1'b0, 0, 0, 6);
    add_row("branch",     if_pkg::PC_BRANCH,   32'h0000_30f0, 25'h0,    5'd0, 2'b10, 1'b0, 0, 0, 6);
    add_row("mret",       if_pkg::PC_MRET,     32'h0000_4100, 25'h0,    5'd0, 2'b10, 1'b0, 0, 0, 6);
    add_row("dret",       if_pkg::PC_DRET,     32'h0000_5200, 25'h0,    5'd0, 2'b10, 1'b0, 0, 0, 6);
    add_row("trap_irq",   if_pkg::PC_TRAP_IRQ, 32'h0,         25'h123,  5'd7, 2'b10, 1'b0, 0, 0, 6);
    add_row("trap_dbd",   if_pkg::PC_TRAP_DBD, 32'h0000_6a07, 25'h0,    5'd0, 2'b10, 1'b0, 0, 0, 6);
    add_row("ready_gaps", if_pkg::PC_JUMP,     32'h0000_7000, 25'h0,    5'd0, 2'b10, 1'b1, 0, 0, 24);
    add_row("halt",       if_pkg::PC_BRANCH,   32'h0000_8000, 25'h0,    5'd0, 2'b11, 1'b0, 0, 0, 12);
    // Window holds a 2'b10 word, which must not be flagged, 0x907c later is
    add_row("err_illegal", if_pkg::PC_JUMP,    32'h0000_9000, 25'h0,    5'd0, 2'b10, 1'b0,
            32'h9030, 32'h9040, 32);
    total = 0;
    for (int r = 0; r < rows; r++) total += t_n[r];
    timeout_limit = 40 * total + 100;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int r = 0; r < rows; r++) run_test(r);
    repeat (5) @(posedge clk);
    mon.summary();
    if (mon.errors == 0 && mon.tests == rows && dut_i.assert_i.failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- all.f
if_pkg.sv
fetch_out_if.sv
pc_select.sv
fetch_fifo.sv
prefetch_unit.sv
if_id_register.sv
if_stage.sv
if_stage_checker.sv
if_stage_monitor.sv
tb_if_stage.sv

//--- Makefile
SRCS := $(shell cat all.f)

.PHONY: run clean

obj_dir/Vtb_if_stage: all.f $(SRCS)
	verilator --binary --timing --assert -f all.f --top-module tb_if_stage -o Vtb_if_stage

run: obj_dir/Vtb_if_stage
	./obj_dir/Vtb_if_stage > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "Simulation failed" sim.log

clean:
	rm -rf obj_dir sim.log
